/* list.f */
+incdir+include
verilog/rv_isa_pkg.sv
verilog/blimp_uarch_pkg.sv
verilog/pipe_ifs.sv
verilog/decode_issue_unit.sv
verilog/alu_unit.sv
verilog/iter_multiplier.sv
verilog/writeback_commit_unit.sv
verilog/blimp_core_top.sv
verif/tb_blimp_core_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_blimp_core_top -f list.f --Mdir obj_dir -o sim_core

./obj_dir/sim_core | tee sim.log

if grep -qx "All checks passed" sim.log; then
  echo "Simulation PASSED"
else
  echo "Simulation FAILED"
  exit 1
fi

/* include/tb_rv_golden.svh */
// Golden model helpers for the core testbench
// Instruction encoders, in-order reference evaluation and the LFSR

`ifndef TB_RV_GOLDEN_SVH
`define TB_RV_GOLDEN_SVH

// Fibonacci LFSR state, taps 32 22 2 1
logic [31:0] lfsr_state;

// One step per bit taken, newest bit in the LSB
function automatic logic [31:0] lfsr_bits(input int n);
  logic [31:0] r;
  logic        fb;
  int          k;
  r = '0;
  for (k = 0; k < n; k++) begin
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    r          = {r[30:0], fb};
  end
  return r;
endfunction

// --------------------------------------------------------------------------
// Encoders
// --------------------------------------------------------------------------

function automatic rv_isa_pkg::inst_t r_type_inst(input logic [6:0] f7,
    input rv_isa_pkg::reg_addr_t rs2, input rv_isa_pkg::reg_addr_t rs1,
    input logic [2:0] f3, input rv_isa_pkg::reg_addr_t rd);
  return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
endfunction

function automatic rv_isa_pkg::inst_t i_type_inst(input logic [11:0] imm,
    input rv_isa_pkg::reg_addr_t rs1, input logic [2:0] f3,
    input rv_isa_pkg::reg_addr_t rd);
  return {imm, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM};
endfunction

function automatic rv_isa_pkg::inst_t lui_inst(input logic [19:0] imm,
    input rv_isa_pkg::reg_addr_t rd);
  return {imm, rd, rv_isa_pkg::OPC_LUI};
endfunction

// --------------------------------------------------------------------------
// Reference evaluation, RV32I subset plus mul
// --------------------------------------------------------------------------

function automatic void ref_exec(input rv_isa_pkg::inst_t i, input rv_isa_pkg::word_t a,
    input rv_isa_pkg::word_t b, output logic legal, output rv_isa_pkg::word_t res);
  rv_isa_pkg::word_t opb;
  logic [6:0]        f7;
  logic [2:0]        f3;
  logic              is_op;
  f7    = i[31:25];
  f3    = i[14:12];
  is_op = (i[6:0] == rv_isa_pkg::OPC_OP);
  opb   = is_op ? b : {{20{i[31]}}, i[31:20]};
  legal = 1'b1;
  res   = '0;
  if (i[6:0] == rv_isa_pkg::OPC_LUI) begin
    res = {i[31:12], 12'b0};
  end else if (!is_op && i[6:0] != rv_isa_pkg::OPC_OP_IMM) begin
    legal = 1'b0;
  end else if (is_op && f7 == rv_isa_pkg::F7_MULDIV) begin
    // Only the low product half is kept
    legal = (f3 == rv_isa_pkg::F3_MUL);
    res   = a * b;
  end else if (f7 == rv_isa_pkg::F7_ALT && f3 == rv_isa_pkg::F3_SRL_SRA) begin
    res = $signed(a) >>> opb[4:0];
  end else if (is_op && f7 == rv_isa_pkg::F7_ALT && f3 == rv_isa_pkg::F3_ADD_SUB) begin
    res = a - b;
  end else if ((is_op || f3 == rv_isa_pkg::F3_SLL || f3 == rv_isa_pkg::F3_SRL_SRA) &&
               f7 != rv_isa_pkg::F7_BASE) begin
    legal = 1'b0;
  end else begin
    case (f3)
      rv_isa_pkg::F3_ADD_SUB: res = a + opb;
      rv_isa_pkg::F3_SLL:     res = a << opb[4:0];
      rv_isa_pkg::F3_SLT:     res = {31'b0, $signed(a) < $signed(opb)};
      rv_isa_pkg::F3_SLTU:    res = {31'b0, a < opb};
      rv_isa_pkg::F3_XOR:     res = a ^ opb;
      rv_isa_pkg::F3_SRL_SRA: res = a >> opb[4:0];
      rv_isa_pkg::F3_OR:      res = a | opb;
      default:                res = a & opb;
    endcase
  end
endfunction

`endif

/* verif/tb_blimp_core_top.sv */
// Testbench for the core top level
// Random and directed RV32I subset programs against an in-order golden
// register file, with the commit trace checked by concurrent assertions

`timescale 1ns/1ps

module tb_blimp_core_top;

  localparam int TIMEOUT_CYCLES = 2000;

  logic                      clk;
  logic                      arst_n;
  logic                      inst_val;
  rv_isa_pkg::inst_t         inst;
  logic                      inst_busy;
  logic                      trace_val;
  blimp_uarch_pkg::seq_num_t trace_seq;
  rv_isa_pkg::reg_addr_t     trace_waddr;
  rv_isa_pkg::word_t         trace_wdata;
  logic                      trace_wen;

  // Golden register file, updated in program order at acceptance
  rv_isa_pkg::word_t     gold_rf [0:31];
  // Expected commit record per seq
  rv_isa_pkg::word_t     exp_wdata [0:31];
  rv_isa_pkg::reg_addr_t exp_waddr [0:31];
  logic                  exp_wen [0:31];
  logic                  exp_legal [0:31];
  int                    acc_cnt [0:31];
  int                    done_cnt [0:31];

  blimp_uarch_pkg::seq_num_t next_seq;
  blimp_uarch_pkg::seq_num_t last_trace_seq;
  int                        acc_total;
  int                        done_total;
  int                        ooo_cnt;
  int                        busy_hold_cnt;
  int                        val_errs;
  int                        oth_errs;
  logic                      timed_out;

  `include "tb_rv_golden.svh"

  blimp_core_top dut0 (
    .clk, .arst_n, .inst_val, .inst, .inst_busy,
    .trace_val, .trace_seq, .trace_waddr, .trace_wdata, .trace_wen
  );

  always #4 clk = ~clk;

  // Trace bookkeeping, away from the rising edge
  always @(negedge clk) begin
    if (arst_n && trace_val) begin
      done_cnt[trace_seq] = done_cnt[trace_seq] + 1;
      done_total++;
      // A gap in seq means something older is still in flight
      if (trace_seq != last_trace_seq + 1'b1) ooo_cnt++;
      last_trace_seq = trace_seq;
    end
  end

  // --------------------------------------------------------------------------
  // Assertions
  // --------------------------------------------------------------------------

  a_quiet_start: assert property (@(posedge clk) disable iff (!arst_n)
    acc_total == 0 |-> !inst_busy && !trace_val)
    else begin
      val_errs++;
      $display("[ERROR] inst_busy %h trace_val %h before first accept, expected 0 0",
               inst_busy, trace_val);
    end

  a_trace_wen: assert property (@(posedge clk) disable iff (!arst_n)
    trace_val |-> trace_wen == exp_wen[trace_seq])
    else begin
      val_errs++;
      $display("[ERROR] trace_wen seq %h: got %h expected %h",
               trace_seq, trace_wen, exp_wen[trace_seq]);
    end

  a_trace_wdata: assert property (@(posedge clk) disable iff (!arst_n)
    trace_val && exp_legal[trace_seq] |-> trace_wdata == exp_wdata[trace_seq])
    else begin
      val_errs++;
      $display("[ERROR] trace_wdata seq %h: got %h expected %h",
               trace_seq, trace_wdata, exp_wdata[trace_seq]);
    end

  a_trace_waddr: assert property (@(posedge clk) disable iff (!arst_n)
    trace_val && exp_legal[trace_seq] |-> trace_waddr == exp_waddr[trace_seq])
    else begin
      val_errs++;
      $display("[ERROR] trace_waddr seq %h: got %h expected %h",
               trace_seq, trace_waddr, exp_waddr[trace_seq]);
    end

  // Exactly one commit per acceptance of a seq
  a_trace_once: assert property (@(posedge clk) disable iff (!arst_n)
    trace_val |-> done_cnt[trace_seq] == acc_cnt[trace_seq])
    else begin
      oth_errs++;
      $display("Commit of seq %0d was never accepted or came twice", trace_seq);
    end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------

  // Hold inst_val high until taken, then log the golden result
  task automatic send_inst(input rv_isa_pkg::inst_t i);
    int                wait_cnt;
    logic              legal;
    rv_isa_pkg::word_t res;
    wait_cnt = 0;
    if (timed_out) return;
    @(negedge clk);
    inst_val = 1'b1;
    inst     = i;
    while (inst_busy && wait_cnt < TIMEOUT_CYCLES) begin
      busy_hold_cnt++;
      wait_cnt++;
      @(negedge clk);
    end
    if (inst_busy) begin
      timed_out = 1'b1;
      oth_errs++;
      $display("Timeout while instruction %h waited for acceptance", i);
      return;
    end
    // inst_busy is settled here, so the next rising edge accepts
    ref_exec(i, gold_rf[i[19:15]], gold_rf[i[24:20]], legal, res);
    exp_legal[next_seq] = legal;
    exp_wdata[next_seq] = res;
    exp_waddr[next_seq] = i[11:7];
    exp_wen[next_seq]   = legal && i[11:7] != 5'd0;
    if (exp_wen[next_seq]) gold_rf[i[11:7]] = res;
    acc_cnt[next_seq] = acc_cnt[next_seq] + 1;
    acc_total++;
    next_seq++;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      inst_val = 1'b0;
    end
  endtask

  // Until every accepted instruction is traced
  task automatic drain_commits();
    int wait_cnt;
    wait_cnt = 0;
    idle_cycles(1);
    while (done_total != acc_total && wait_cnt < TIMEOUT_CYCLES && !timed_out) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (done_total != acc_total && !timed_out) begin
      timed_out = 1'b1;
      oth_errs++;
      $display("Timeout with %0d accepted instructions never traced", acc_total - done_total);
    end
  endtask

  // Random subset instruction, mul optional
  function automatic rv_isa_pkg::inst_t rand_inst(input logic with_mul);
    logic [3:0]            kind;
    logic [2:0]            f3;
    logic                  alt;
    rv_isa_pkg::reg_addr_t rd;
    rv_isa_pkg::reg_addr_t rs1;
    rv_isa_pkg::reg_addr_t rs2;
    rv_isa_pkg::inst_t     i;
    kind = 4'(lfsr_bits(4));
    f3   = 3'(lfsr_bits(3));
    alt  = 1'(lfsr_bits(1));
    rd   = rv_isa_pkg::reg_addr_t'(lfsr_bits(5));
    rs1  = rv_isa_pkg::reg_addr_t'(lfsr_bits(5));
    rs2  = rv_isa_pkg::reg_addr_t'(lfsr_bits(5));
    if (kind < 4'd8) begin
      // Alternate funct7 only for sub and sra
      alt = alt && (f3 == rv_isa_pkg::F3_ADD_SUB || f3 == rv_isa_pkg::F3_SRL_SRA);
      i = r_type_inst(alt ? rv_isa_pkg::F7_ALT : rv_isa_pkg::F7_BASE, rs2, rs1, f3, rd);
    end else if (kind < 4'd13) begin
      if (f3 == rv_isa_pkg::F3_SLL) begin
        i = i_type_inst({rv_isa_pkg::F7_BASE, rs2}, rs1, f3, rd);
      end else if (f3 == rv_isa_pkg::F3_SRL_SRA) begin
        i = i_type_inst({(alt ? rv_isa_pkg::F7_ALT : rv_isa_pkg::F7_BASE), rs2}, rs1, f3, rd);
      end else begin
        i = i_type_inst(12'(lfsr_bits(12)), rs1, f3, rd);
      end
    end else if (kind < 4'd15 || !with_mul) begin
      i = lui_inst(20'(lfsr_bits(20)), rd);
    end else begin
      i = r_type_inst(rv_isa_pkg::F7_MULDIV, rs2, rs1, rv_isa_pkg::F3_MUL, rd);
    end
    return i;
  endfunction

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial begin
    int r;
    clk            = 1'b0;
    arst_n         = 1'b0;
    inst_val       = 1'b0;
    inst           = '0;
    lfsr_state     = 32'h9922d2f3;
    next_seq       = '0;
    last_trace_seq = 5'd31;
    acc_total      = 0;
    done_total     = 0;
    ooo_cnt        = 0;
    busy_hold_cnt  = 0;
    val_errs       = 0;
    oth_errs       = 0;
    timed_out      = 1'b0;
    for (r = 0; r < 32; r++) begin
      gold_rf[r]   = '0;
      exp_wdata[r] = '0;
      exp_waddr[r] = '0;
      exp_wen[r]   = 1'b0;
      exp_legal[r] = 1'b0;
      acc_cnt[r]   = 0;
      done_cnt[r]  = 0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    idle_cycles(6);

    // Nonzero values in x1..x15
    for (r = 1; r < 16; r++) begin
      send_inst(lui_inst(20'(lfsr_bits(20)), 5'(r)));
      send_inst(i_type_inst(12'(lfsr_bits(12)), 5'(r), rv_isa_pkg::F3_ADD_SUB, 5'(r)));
    end
    // Write to x0 is dropped
    send_inst(i_type_inst(12'h07f, 5'd1, rv_isa_pkg::F3_ADD_SUB, 5'd0));

    // Product, independent work that overtakes it, then a consumer
    send_inst(r_type_inst(rv_isa_pkg::F7_MULDIV, 5'd2, 5'd1, rv_isa_pkg::F3_MUL, 5'd20));
    send_inst(i_type_inst(12'h123, 5'd3, rv_isa_pkg::F3_XOR, 5'd21));
    send_inst(r_type_inst(rv_isa_pkg::F7_ALT, 5'd5, 5'd4, rv_isa_pkg::F3_ADD_SUB, 5'd22));
    send_inst(i_type_inst({rv_isa_pkg::F7_ALT, 5'd7}, 5'd6, rv_isa_pkg::F3_SRL_SRA, 5'd23));
    send_inst(r_type_inst(rv_isa_pkg::F7_BASE, 5'd20, 5'd8, rv_isa_pkg::F3_ADD_SUB, 5'd24));
    // Back to back products, the second waits on a busy pipe
    send_inst(r_type_inst(rv_isa_pkg::F7_MULDIV, 5'd24, 5'd9, rv_isa_pkg::F3_MUL, 5'd0));
    send_inst(r_type_inst(rv_isa_pkg::F7_MULDIV, 5'd11, 5'd10, rv_isa_pkg::F3_MUL, 5'd25));
    drain_commits();

    // Self-dependent chain with inst_val held high
    for (r = 0; r < 8; r++) begin
      send_inst(i_type_inst(12'd1, 5'd25, rv_isa_pkg::F3_ADD_SUB, 5'd25));
    end

    // Unsupported encodings: load, div, bad slli, bad xor funct7, all zero
    send_inst({12'h004, 5'd1, 3'b010, 5'd26, 7'b0000011});
    send_inst(r_type_inst(rv_isa_pkg::F7_MULDIV, 5'd2, 5'd1, 3'b100, 5'd27));
    send_inst(i_type_inst({rv_isa_pkg::F7_ALT, 5'd3}, 5'd1, rv_isa_pkg::F3_SLL, 5'd28));
    send_inst(r_type_inst(rv_isa_pkg::F7_ALT, 5'd2, 5'd1, rv_isa_pkg::F3_XOR, 5'd29));
    send_inst('0);

    // Random mix
    for (r = 0; r < 150; r++) begin
      send_inst(rand_inst(1'b1));
    end
    drain_commits();

    // Read back every register through the pipe
    for (r = 1; r < 32; r++) begin
      send_inst(i_type_inst(12'd0, 5'(r), rv_isa_pkg::F3_ADD_SUB, 5'(r)));
    end
    drain_commits();
    idle_cycles(4);

    a_all_traced: assert (done_total == acc_total)
      else begin
        oth_errs++;
        $display("Accepted %0d instructions but traced %0d", acc_total, done_total);
      end
    a_reordered: assert (ooo_cnt > 0)
      else begin
        oth_errs++;
        $display("No instruction ever completed ahead of an older one");
      end
    a_stalled: assert (busy_hold_cnt > 0)
      else begin
        oth_errs++;
        $display("inst_busy never rose while an instruction was offered");
      end

    $display("Errors: %0d value, %0d other, %0d instructions traced",
             val_errs, oth_errs, done_total);
    if (val_errs == 0 && oth_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* verilog/alu_unit.sv */
// Single-cycle ALU pipe
// Registers its result and holds it toward writeback until granted

`timescale 1ns/1ps

module alu_unit (
  input logic clk,
  input logic arst_n,
  d_x_if.pipe d,
  x_w_if.pipe w
);

  rv_isa_pkg::word_t result;
  logic [4:0]        shamt;
  logic              r_val;

  assign shamt = d.op_b[4:0];

  always_comb begin
    case (d.op)
      blimp_uarch_pkg::ALU_ADD:      result = d.op_a + d.op_b;
      blimp_uarch_pkg::ALU_SUB:      result = d.op_a - d.op_b;
      blimp_uarch_pkg::ALU_AND:      result = d.op_a & d.op_b;
      blimp_uarch_pkg::ALU_OR:       result = d.op_a | d.op_b;
      blimp_uarch_pkg::ALU_XOR:      result = d.op_a ^ d.op_b;
      blimp_uarch_pkg::ALU_SLT:      result = {31'b0, $signed(d.op_a) < $signed(d.op_b)};
      blimp_uarch_pkg::ALU_SLTU:     result = {31'b0, d.op_a < d.op_b};
      blimp_uarch_pkg::ALU_SLL:      result = d.op_a << shamt;
      blimp_uarch_pkg::ALU_SRL:      result = d.op_a >> shamt;
      blimp_uarch_pkg::ALU_SRA:      result = $signed(d.op_a) >>> shamt;
      blimp_uarch_pkg::ALU_LUI_PASS: result = d.op_b;
      // nop and anything else
      default:                       result = '0;
    endcase
  end

  // Free again in the grant cycle
  assign d.busy = r_val && !w.gnt;
  assign w.val  = r_val;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      r_val <= 1'b0;
    end else if (d.val) begin
      r_val <= 1'b1;
    end else if (w.gnt) begin
      r_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (d.val) begin
      w.wdata <= result;
      w.seq   <= d.seq;
      w.waddr <= d.waddr;
      w.wen   <= d.wen;
    end
  end

endmodule

/* verilog/blimp_core_top.sv */
// Core top level
// Decode, ALU and multiplier pipes and writeback, with plain instruction
// ports in and a commit trace out

`timescale 1ns/1ps

module blimp_core_top (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      inst_val,
  input  rv_isa_pkg::inst_t         inst,
  output logic                      inst_busy,
  output logic                      trace_val,
  output blimp_uarch_pkg::seq_num_t trace_seq,
  output rv_isa_pkg::reg_addr_t     trace_waddr,
  output rv_isa_pkg::word_t         trace_wdata,
  output logic                      trace_wen
);

  // --------------------------------------------------------------------------
  // Interfaces
  // --------------------------------------------------------------------------

  d_x_if    alu_dx ();
  d_x_if    mul_dx ();
  x_w_if    alu_xw ();
  x_w_if    mul_xw ();
  commit_if commit ();

  // --------------------------------------------------------------------------
  // Units
  // --------------------------------------------------------------------------

  decode_issue_unit diu0 (.clk, .arst_n, .inst_val, .inst, .inst_busy,
                          .alu(alu_dx), .mul(mul_dx), .commit(commit));

  alu_unit alu0 (.clk, .arst_n, .d(alu_dx), .w(alu_xw));

  iter_multiplier mul0 (.clk, .arst_n, .d(mul_dx), .w(mul_xw));

  writeback_commit_unit wcu0 (.clk, .arst_n, .alu(alu_xw), .mul(mul_xw), .commit(commit));

  // Trace is the commit record
  assign trace_val   = commit.val;
  assign trace_seq   = commit.seq;
  assign trace_waddr = commit.waddr;
  assign trace_wdata = commit.wdata;
  assign trace_wen   = commit.wen;

endmodule

/* verilog/blimp_uarch_pkg.sv */
// Core microarchitecture definitions
// Operation encoding toward the ALU, sequence numbers, pipe indices and
// the multiplier state machine

package blimp_uarch_pkg;

  // Tag given at acceptance, wraps
  typedef logic [4:0] seq_num_t;

  // --------------------------------------------------------------------------
  // Execute pipes
  // --------------------------------------------------------------------------

  localparam int NUM_PIPES = 2;
  localparam int PIPE_ALU  = 0;
  localparam int PIPE_MUL  = 1;

  // Shift-add iterations, one bit per cycle
  localparam int MUL_CYCLES = 32;

  // Iteration count, must reach MUL_CYCLES itself
  typedef logic [$clog2(MUL_CYCLES + 1)-1:0] mul_cnt_t;

  // --------------------------------------------------------------------------
  // Encodings
  // --------------------------------------------------------------------------

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_LUI_PASS,
    ALU_NOP
  } alu_op_e;

  typedef enum logic [1:0] {
    MUL_IDLE,
    MUL_BUSY,
    MUL_DONE
  } mul_state_e;

endpackage

/* verilog/decode_issue_unit.sv */
// Decode and issue unit
// Holds one instruction, decodes it, reads the register file with commit
// bypass and issues to the ALU or multiplier once the scoreboard is clear

`timescale 1ns/1ps

module decode_issue_unit (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              inst_val,
  input  rv_isa_pkg::inst_t inst,
  output logic              inst_busy,
  d_x_if.decode             alu,
  d_x_if.decode             mul,
  commit_if.sink            commit
);

  // Decode register
  logic                      dr_val;
  rv_isa_pkg::inst_t         dr_inst;
  blimp_uarch_pkg::seq_num_t dr_seq;
  blimp_uarch_pkg::seq_num_t seq_ctr;

  // Architectural state, x0 not stored
  rv_isa_pkg::word_t rf [1:31];
  logic [31:0]       sb;
  logic [31:0]       sb_set;
  logic [31:0]       sb_clr;
  logic [31:0]       sb_eff;

  // Fields
  rv_isa_pkg::opcode_t   opcode;
  rv_isa_pkg::reg_addr_t rd;
  rv_isa_pkg::reg_addr_t rs1;
  rv_isa_pkg::reg_addr_t rs2;
  logic [2:0]            f3;
  logic [6:0]            f7;
  rv_isa_pkg::word_t     imm_i;
  rv_isa_pkg::word_t     imm_u;
  rv_isa_pkg::word_t     rs1_val;
  rv_isa_pkg::word_t     rs2_val;

  blimp_uarch_pkg::alu_op_e d_op;
  logic                     d_mul;
  logic                     d_legal;
  logic                     d_wen;
  logic                     hazard;
  logic                     issue;
  logic                     accept;

  assign opcode = dr_inst[6:0];
  assign rd     = dr_inst[11:7];
  assign f3     = dr_inst[14:12];
  assign rs1    = dr_inst[19:15];
  assign rs2    = dr_inst[24:20];
  assign f7     = dr_inst[31:25];
  assign imm_i  = {{20{dr_inst[31]}}, dr_inst[31:20]};
  assign imm_u  = {dr_inst[31:12], 12'b0};

  // funct3 to ALU op; alt picks sub or sra
  function automatic blimp_uarch_pkg::alu_op_e f3_to_op(input logic [2:0] fn3, input logic alt);
    blimp_uarch_pkg::alu_op_e op;
    case (fn3)
      rv_isa_pkg::F3_ADD_SUB: op = alt ? blimp_uarch_pkg::ALU_SUB : blimp_uarch_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:     op = blimp_uarch_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:     op = blimp_uarch_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU:    op = blimp_uarch_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:     op = blimp_uarch_pkg::ALU_XOR;
      rv_isa_pkg::F3_SRL_SRA: op = alt ? blimp_uarch_pkg::ALU_SRA : blimp_uarch_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:      op = blimp_uarch_pkg::ALU_OR;
      default:                op = blimp_uarch_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  // --------------------------------------------------------------------------
  // Decode
  // --------------------------------------------------------------------------

  always_comb begin
    d_op    = blimp_uarch_pkg::ALU_NOP;
    d_mul   = 1'b0;
    d_legal = 1'b0;
    case (opcode)
      rv_isa_pkg::OPC_OP: begin
        if (f7 == rv_isa_pkg::F7_MULDIV && f3 == rv_isa_pkg::F3_MUL) begin
          d_mul   = 1'b1;
          d_legal = 1'b1;
        end else if (f7 == rv_isa_pkg::F7_BASE || (f7 == rv_isa_pkg::F7_ALT &&
                     (f3 == rv_isa_pkg::F3_ADD_SUB || f3 == rv_isa_pkg::F3_SRL_SRA))) begin
          d_op    = f3_to_op(f3, f7 == rv_isa_pkg::F7_ALT);
          d_legal = 1'b1;
        end
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        // Shift immediates constrain the upper bits, the rest do not
        if ((f3 != rv_isa_pkg::F3_SLL && f3 != rv_isa_pkg::F3_SRL_SRA) ||
            f7 == rv_isa_pkg::F7_BASE ||
            (f3 == rv_isa_pkg::F3_SRL_SRA && f7 == rv_isa_pkg::F7_ALT)) begin
          d_op    = f3_to_op(f3, f3 == rv_isa_pkg::F3_SRL_SRA && f7 == rv_isa_pkg::F7_ALT);
          d_legal = 1'b1;
        end
      end
      rv_isa_pkg::OPC_LUI: begin
        d_op    = blimp_uarch_pkg::ALU_LUI_PASS;
        d_legal = 1'b1;
      end
      default: d_op = blimp_uarch_pkg::ALU_NOP;
    endcase
  end

  // Unsupported encodings and x0 targets retire without a write
  assign d_wen = d_legal && (rd != 5'd0);

  // Operand read with same-cycle commit bypass
  always_comb begin
    rs1_val = (rs1 == 5'd0) ? '0 : rf[rs1];
    rs2_val = (rs2 == 5'd0) ? '0 : rf[rs2];
    if (commit.val && commit.wen && commit.waddr == rs1 && rs1 != 5'd0) rs1_val = commit.wdata;
    if (commit.val && commit.wen && commit.waddr == rs2 && rs2 != 5'd0) rs2_val = commit.wdata;
  end

  // --------------------------------------------------------------------------
  // Scoreboard and issue
  // --------------------------------------------------------------------------

  // Bits released by this cycle's commit count as clear
  assign sb_clr = (commit.val && commit.wen) ? (32'd1 << commit.waddr) : '0;
  assign sb_eff = sb & ~sb_clr;

  // Sources, then destination for WAW
  assign hazard = (d_legal && opcode != rv_isa_pkg::OPC_LUI && sb_eff[rs1]) ||
                  (d_legal && opcode == rv_isa_pkg::OPC_OP && sb_eff[rs2]) ||
                  (d_wen && sb_eff[rd]);

  assign issue     = dr_val && !hazard && !(d_mul ? mul.busy : alu.busy);
  assign inst_busy = dr_val && !issue;
  assign accept    = inst_val && !inst_busy;
  assign sb_set    = (issue && d_wen) ? (32'd1 << rd) : '0;

  // Both pipes see the same record, val picks one
  assign alu.val   = issue && !d_mul;
  assign mul.val   = issue && d_mul;
  assign alu.seq   = dr_seq;
  assign mul.seq   = dr_seq;
  assign alu.op    = d_op;
  assign mul.op    = d_op;
  assign alu.op_a  = rs1_val;
  assign mul.op_a  = rs1_val;
  assign alu.op_b  = (opcode == rv_isa_pkg::OPC_OP) ? rs2_val :
                     (opcode == rv_isa_pkg::OPC_LUI) ? imm_u : imm_i;
  assign mul.op_b  = rs2_val;
  assign alu.waddr = rd;
  assign mul.waddr = rd;
  assign alu.wen   = d_wen;
  assign mul.wen   = d_wen;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dr_val  <= 1'b0;
      seq_ctr <= '0;
      sb      <= '0;
      for (int i = 1; i < 32; i++) rf[i] <= '0;
    end else begin
      if (accept) begin
        dr_val  <= 1'b1;
        seq_ctr <= seq_ctr + 1'b1;
      end else if (issue) begin
        dr_val <= 1'b0;
      end
      sb <= sb_eff | sb_set;
      if (commit.val && commit.wen && commit.waddr != 5'd0) rf[commit.waddr] <= commit.wdata;
    end
  end

  // Payload of the decode register
  always_ff @(posedge clk) begin
    if (accept) begin
      dr_inst <= inst;
      dr_seq  <= seq_ctr;
    end
  end

  // No issue strobe toward a pipe that reports busy
  a_alu_no_issue_busy: assert property (@(posedge clk) disable iff (!arst_n)
    alu.val |-> !alu.busy);
  a_mul_no_issue_busy: assert property (@(posedge clk) disable iff (!arst_n)
    mul.val |-> !mul.busy);

endmodule

/* verilog/iter_multiplier.sv */
// Iterative multiplier pipe
// Shift-add, one multiplier bit per cycle, low 32 bits of the product

`timescale 1ns/1ps

module iter_multiplier (
  input logic clk,
  input logic arst_n,
  d_x_if.pipe d,
  x_w_if.pipe w
);

  blimp_uarch_pkg::mul_state_e state;
  blimp_uarch_pkg::mul_cnt_t   cnt;
  rv_isa_pkg::word_t           mcand;
  rv_isa_pkg::word_t           mplier;
  logic                        last;

  assign last   = (cnt == blimp_uarch_pkg::mul_cnt_t'(blimp_uarch_pkg::MUL_CYCLES - 1));
  assign d.busy = (state != blimp_uarch_pkg::MUL_IDLE);
  assign w.val  = (state == blimp_uarch_pkg::MUL_DONE);

  // --------------------------------------------------------------------------
  // Control
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= blimp_uarch_pkg::MUL_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        blimp_uarch_pkg::MUL_IDLE: begin
          if (d.val) begin
            state <= blimp_uarch_pkg::MUL_BUSY;
            cnt   <= '0;
          end
        end
        blimp_uarch_pkg::MUL_BUSY: begin
          // Result valid right after the last add
          cnt <= cnt + 1'b1;
          if (last) state <= blimp_uarch_pkg::MUL_DONE;
        end
        blimp_uarch_pkg::MUL_DONE: begin
          if (w.gnt) state <= blimp_uarch_pkg::MUL_IDLE;
        end
        default: state <= blimp_uarch_pkg::MUL_IDLE;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Datapath
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (d.val) begin
      w.wdata <= '0;
      mcand   <= d.op_a;
      mplier  <= d.op_b;
      w.seq   <= d.seq;
      w.waddr <= d.waddr;
      w.wen   <= d.wen;
    end else if (state == blimp_uarch_pkg::MUL_BUSY) begin
      if (mplier[0]) w.wdata <= w.wdata + mcand;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // Counter bound and fixed latency from issue to result
  a_cnt_bound: assert property (@(posedge clk) disable iff (!arst_n)
    cnt <= blimp_uarch_pkg::mul_cnt_t'(blimp_uarch_pkg::MUL_CYCLES));
  a_val_after_count: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(w.val) |-> $past(last) && state == blimp_uarch_pkg::MUL_DONE);
  a_latency: assert property (@(posedge clk) disable iff (!arst_n)
    d.val |=> !w.val [*blimp_uarch_pkg::MUL_CYCLES] ##1 w.val);

endmodule

/* verilog/pipe_ifs.sv */
// Pipeline interfaces of the core
// Decode to execute, execute to writeback, and the commit broadcast

`timescale 1ns/1ps

// Decode to one execute pipe
// val is a strobe, only raised while busy is low
interface d_x_if;
  logic                      val;
  blimp_uarch_pkg::seq_num_t seq;
  blimp_uarch_pkg::alu_op_e  op;
  rv_isa_pkg::word_t         op_a;
  rv_isa_pkg::word_t         op_b;
  rv_isa_pkg::reg_addr_t     waddr;
  logic                      wen;
  logic                      busy;

  modport decode (
    output val, seq, op, op_a, op_b, waddr, wen,
    input  busy
  );

  modport pipe (
    input  val, seq, op, op_a, op_b, waddr, wen,
    output busy
  );
endinterface

// Execute pipe to writeback
// val and payload held steady until the gnt cycle
interface x_w_if;
  logic                      val;
  blimp_uarch_pkg::seq_num_t seq;
  rv_isa_pkg::reg_addr_t     waddr;
  rv_isa_pkg::word_t         wdata;
  logic                      wen;
  logic                      gnt;

  modport pipe (
    output val, seq, waddr, wdata, wen,
    input  gnt
  );

  modport wb (
    input  val, seq, waddr, wdata, wen,
    output gnt
  );
endinterface

// Commit broadcast, one record per retired instruction
interface commit_if;
  logic                      val;
  blimp_uarch_pkg::seq_num_t seq;
  rv_isa_pkg::reg_addr_t     waddr;
  rv_isa_pkg::word_t         wdata;
  logic                      wen;

  modport source (output val, seq, waddr, wdata, wen);
  modport sink   (input  val, seq, waddr, wdata, wen);
endinterface

/* verilog/rv_isa_pkg.sv */
// RV32I subset encodings
// Major opcodes, funct3 and funct7 values and the field types used by
// decode and by the execute pipes

package rv_isa_pkg;

  // --------------------------------------------------------------------------
  // Field types
  // --------------------------------------------------------------------------

  typedef logic [31:0] word_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [6:0]  opcode_t;

  // --------------------------------------------------------------------------
  // Major opcodes kept
  // --------------------------------------------------------------------------

  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;

  // funct3, shared by reg-reg and reg-imm forms
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  // mul lives under OPC_OP with the M extension funct7
  localparam logic [2:0] F3_MUL     = 3'b000;

  // funct7
  localparam logic [6:0] F7_BASE   = 7'b0000000;
  // sub and sra
  localparam logic [6:0] F7_ALT    = 7'b0100000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

endpackage

/* verilog/writeback_commit_unit.sv */
// Writeback and commit unit
// Fixed priority grant, multiplier over ALU, registered commit record

`timescale 1ns/1ps

module writeback_commit_unit (
  input logic      clk,
  input logic      arst_n,
  x_w_if.wb        alu,
  x_w_if.wb        mul,
  commit_if.source commit
);

  logic [blimp_uarch_pkg::NUM_PIPES-1:0] gnt;

  // Long pipe first, it holds back no one behind it
  always_comb begin
    gnt = '0;
    if (mul.val)      gnt[blimp_uarch_pkg::PIPE_MUL] = 1'b1;
    else if (alu.val) gnt[blimp_uarch_pkg::PIPE_ALU] = 1'b1;
  end

  assign mul.gnt = gnt[blimp_uarch_pkg::PIPE_MUL];
  assign alu.gnt = gnt[blimp_uarch_pkg::PIPE_ALU];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) commit.val <= 1'b0;
    else         commit.val <= |gnt;
  end

  always_ff @(posedge clk) begin
    if (gnt[blimp_uarch_pkg::PIPE_MUL]) begin
      commit.seq   <= mul.seq;
      commit.waddr <= mul.waddr;
      commit.wdata <= mul.wdata;
      commit.wen   <= mul.wen;
    end else if (gnt[blimp_uarch_pkg::PIPE_ALU]) begin
      commit.seq   <= alu.seq;
      commit.waddr <= alu.waddr;
      commit.wdata <= alu.wdata;
      commit.wen   <= alu.wen;
    end
  end

  // One grant at most, and a waiting ALU result stays put
  a_one_grant: assert property (@(posedge clk) disable iff (!arst_n)
    !(alu.gnt && mul.gnt));
  a_alu_hold: assert property (@(posedge clk) disable iff (!arst_n)
    alu.val && !alu.gnt |=> alu.val && $stable(alu.seq));

endmodule
